/* hdl/apb_decoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module apb_decoder (
    input logic   CLOCK_50,
    input logic   KEY0,
    apb_if.slave  host,
    apb_if.master ram,
    apb_if.master keys
);
    import soc_pkg::*;

    localparam logic [`SOC_ADDR_W-1:0] ram_bytes = `RAM_WORDS * 4;
    localparam logic [`SOC_ADDR_W-1:0] key_bytes = `KEY_WORDS * 4;

    logic [`SOC_ADDR_W-1:0] ram_ofs;
    logic [`SOC_ADDR_W-1:0] key_ofs;
    bus_region_t            region;
    logic                   none_resp;

    // Offsets relative to each window, so one unsigned compare covers both bounds
    assign ram_ofs = host.paddr - `RAM_BASE;
    assign key_ofs = host.paddr - `KEY_BASE;

    always_comb begin
        if (ram_ofs < ram_bytes)
            region = REGION_RAM;
        else if (key_ofs < key_bytes)
            region = REGION_KEY;
        else
            region = REGION_NONE;
    end

    // Only the selected slave sees psel and penable
    assign ram.psel     = host.psel && (region == REGION_RAM);
    assign ram.penable  = host.penable && (region == REGION_RAM);
    assign ram.pwrite   = host.pwrite;
    assign ram.paddr    = host.paddr;
    assign ram.pwdata   = host.pwdata;

    assign keys.psel    = host.psel && (region == REGION_KEY);
    assign keys.penable = host.penable && (region == REGION_KEY);
    assign keys.pwrite  = host.pwrite;
    assign keys.paddr   = host.paddr;
    assign keys.pwdata  = host.pwdata;

    // Unmapped access: armed in the setup cycle, answers in the first access cycle
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            none_resp <= 1'b0;
        end else begin
            none_resp <= host.psel && !host.penable && (region == REGION_NONE);
        end
    end

    always_comb begin
        case (region)
            REGION_RAM: begin
                host.prdata  = ram.prdata;
                host.pready  = ram.pready;
                host.pslverr = ram.pslverr;
            end
            REGION_KEY: begin
                host.prdata  = keys.prdata;
                host.pready  = keys.pready;
                host.pslverr = keys.pslverr;
            end
            default: begin
                host.prdata  = '0;
                host.pready  = none_resp;
                host.pslverr = none_resp;
            end
        endcase
    end

endmodule

`default_nettype wire

/* hdl/apb_if.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

interface apb_if;

    // Request side, driven by the master
    logic                   psel;
    logic                   penable;
    logic                   pwrite;
    logic [`SOC_ADDR_W-1:0] paddr;
    logic [`SOC_DATA_W-1:0] pwdata;

    // Response side, driven by the slave
    logic [`SOC_DATA_W-1:0] prdata;
    logic                   pready;
    logic                   pslverr;

    modport master (
        output psel, penable, pwrite, paddr, pwdata,
        input  prdata, pready, pslverr
    );

    modport slave (
        input  psel, penable, pwrite, paddr, pwdata,
        output prdata, pready, pslverr
    );

endinterface

`default_nettype wire

/* hdl/board_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module board_top (
    input  logic                   CLOCK_50,
    input  logic                   KEY0,
    input  logic                   PS2_CLK,
    input  logic                   PS2_DAT,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [`SOC_ADDR_W-1:0] paddr,
    input  logic [`SOC_DATA_W-1:0] pwdata,
    output logic [`SOC_DATA_W-1:0] prdata,
    output logic                   pready,
    output logic                   pslverr,
    output logic                   irq
);
    import soc_pkg::*;

    apb_if host_bus ();
    apb_if ram_bus ();
    apb_if key_bus ();

    logic       event_valid;
    key_event_t key_event;
    logic       frame_error;

    // External master onto the host bus
    assign host_bus.psel    = psel;
    assign host_bus.penable = penable;
    assign host_bus.pwrite  = pwrite;
    assign host_bus.paddr   = paddr;
    assign host_bus.pwdata  = pwdata;
    assign prdata           = host_bus.prdata;
    assign pready           = host_bus.pready;
    assign pslverr          = host_bus.pslverr;

    apb_decoder apb_decoder_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .host     (host_bus.slave),
        .ram      (ram_bus.master),
        .keys     (key_bus.master)
    );

    word_ram word_ram_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .bus      (ram_bus.slave)
    );

    ps2_receiver ps2_receiver_inst (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .ps2_clk     (PS2_CLK),
        .ps2_dat     (PS2_DAT),
        .event_valid (event_valid),
        .key_event   (key_event),
        .frame_error (frame_error)
    );

    key_regs key_regs_inst (
        .CLOCK_50    (CLOCK_50),
        .KEY0        (KEY0),
        .bus         (key_bus.slave),
        .event_valid (event_valid),
        .key_event   (key_event),
        .frame_error (frame_error),
        .irq         (irq)
    );

endmodule

`default_nettype wire

/* hdl/key_regs.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module key_regs (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    apb_if.slave               bus,
    input  logic               event_valid,
    input  soc_pkg::key_event_t key_event,
    input  logic               frame_error,
    output logic               irq
);
    import soc_pkg::*;

    localparam logic [1:0] reg_data   = 2'(`KEY_DATA_OFS >> 2);
    localparam logic [1:0] reg_status = 2'(`KEY_STATUS_OFS >> 2);
    localparam logic [1:0] reg_ctrl   = 2'(`KEY_CTRL_OFS >> 2);

    logic [`SOC_ADDR_W-1:0] offset;
    logic [1:0]             reg_idx;
    logic                   access;
    logic                   data_read;
    logic                   status_wr;
    logic                   ctrl_wr;
    key_event_t             data_q;
    logic                   pending;
    logic                   overrun;
    logic                   ferr;
    logic                   irq_en;

    assign offset  = bus.paddr - `KEY_BASE;
    assign reg_idx = offset[3:2];
    assign access  = bus.psel & bus.penable;

    // Strobes on the completing edge
    assign data_read = access && !bus.pwrite && (reg_idx == reg_data);
    assign status_wr = access && bus.pwrite && (reg_idx == reg_status);
    assign ctrl_wr   = access && bus.pwrite && (reg_idx == reg_ctrl);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            pending <= 1'b0;
            overrun <= 1'b0;
            ferr    <= 1'b0;
            irq_en  <= 1'b0;
            irq     <= 1'b0;
        end else begin
            // A new event wins over a read in the same cycle
            if (event_valid)
                pending <= 1'b1;
            else if (data_read)
                pending <= 1'b0;

            // Overrun only if the old event is still unread
            if (event_valid && pending && !data_read)
                overrun <= 1'b1;
            else if (status_wr && bus.pwdata[1])
                overrun <= 1'b0;

            if (frame_error)
                ferr <= 1'b1;
            else if (status_wr && bus.pwdata[2])
                ferr <= 1'b0;

            if (ctrl_wr)
                irq_en <= bus.pwdata[0];

            irq <= pending & irq_en;
        end
    end

    // Latest event, replaced on overrun
    always_ff @(posedge CLOCK_50) begin
        if (event_valid) begin
            data_q <= key_event;
        end
    end

    always_comb begin
        bus.prdata = '0;
        case (reg_idx)
            reg_data:   bus.prdata[$bits(key_event_t)-1:0] = data_q;
            reg_status: bus.prdata[2:0] = {ferr, overrun, pending};
            reg_ctrl:   bus.prdata[0] = irq_en;
            default:    bus.prdata = '0;
        endcase
    end

    // No wait states, writes to KEY_DATA fall through silently
    assign bus.pready  = access;
    assign bus.pslverr = 1'b0;

endmodule

`default_nettype wire

/* hdl/ps2_receiver.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module ps2_receiver (
    input  logic               CLOCK_50,
    input  logic               KEY0,
    input  logic               ps2_clk,
    input  logic               ps2_dat,
    output logic               event_valid,
    output soc_pkg::key_event_t key_event,
    output logic               frame_error
);

    localparam int idx_w = $clog2(`PS2_IDLE_LIMIT);
    localparam logic [idx_w-1:0] idle_max = idx_w'(`PS2_IDLE_LIMIT - 1);

    logic [1:0]       clk_sync;
    logic [1:0]       dat_sync;
    logic             clk_prev;
    logic             clk_fall;
    logic [3:0]       bit_cnt;
    logic [9:0]       shreg;
    logic [idx_w-1:0] idle_cnt;
    logic             break_armed;
    logic             frame_done;
    logic             frame_ok;
    logic [7:0]       code;

    // Both lines idle high
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            clk_sync <= 2'b11;
            dat_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
            clk_prev <= clk_sync[1];
        end
    end

    assign clk_fall   = clk_prev & ~clk_sync[1];
    // The 11th fall carries the stop bit, still on the data line
    assign frame_done = clk_fall && (bit_cnt == 4'd10);
    assign code       = shreg[8:1];
    // Start low, stop high, odd parity over data and parity bit
    assign frame_ok   = !shreg[0] && dat_sync[1] && (^shreg[9:1]);

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt     <= '0;
            idle_cnt    <= '0;
            break_armed <= 1'b0;
            event_valid <= 1'b0;
            frame_error <= 1'b0;
        end else begin
            event_valid <= 1'b0;
            frame_error <= 1'b0;
            if (clk_fall) begin
                idle_cnt <= '0;
                if (frame_done) begin
                    bit_cnt <= '0;
                    if (!frame_ok) begin
                        frame_error <= 1'b1;
                        break_armed <= 1'b0;
                    end else if (code == 8'hF0) begin
                        // Break prefix, wait for the code that follows
                        break_armed <= 1'b1;
                    end else begin
                        event_valid <= 1'b1;
                        break_armed <= 1'b0;
                    end
                end else begin
                    bit_cnt <= bit_cnt + 4'd1;
                end
            end else if (bit_cnt != 4'd0) begin
                // Watchdog on a stalled frame
                if (idle_cnt == idle_max) begin
                    bit_cnt  <= '0;
                    idle_cnt <= '0;
                end else begin
                    idle_cnt <= idle_cnt + 1'b1;
                end
            end
        end
    end

    // Shift LSB first, first bit ends up at shreg[0]
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall && !frame_done) begin
            shreg <= {dat_sync[1], shreg[9:1]};
        end
        if (frame_done && frame_ok && (code != 8'hF0)) begin
            key_event.released <= break_armed;
            key_event.scan     <= code;
        end
    end

endmodule

`default_nettype wire

/* hdl/soc_pkg.sv */
`default_nettype none

package soc_pkg;

    // Which slave an APB address lands on
    typedef enum logic [1:0] {
        REGION_RAM,
        REGION_KEY,
        REGION_NONE
    } bus_region_t;

    // One key event from the PS/2 receiver
    // Also the low 9 bits of KEY_DATA
    typedef struct packed {
        logic       released;
        logic [7:0] scan;
    } key_event_t;

endpackage

`default_nettype wire

/* hdl/word_ram.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module word_ram (
    input logic  CLOCK_50,
    input logic  KEY0,
    apb_if.slave bus
);

    localparam int idx_w = $clog2(`RAM_WORDS);

    logic [`SOC_DATA_W-1:0] mem [`RAM_WORDS];
    logic [`SOC_ADDR_W-1:0] offset;
    logic [idx_w-1:0]       word_idx;
    logic                   access;
    logic                   wait_done;
    logic [`SOC_DATA_W-1:0] rdata;

    assign offset   = bus.paddr - `RAM_BASE;
    assign word_idx = offset[idx_w+1:2];
    assign access   = bus.psel & bus.penable;

    // High in the second access cycle only
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wait_done <= 1'b0;
        end else if (access) begin
            wait_done <= !wait_done;
        end
    end

    // Read during the wait state, write on the completing edge
    always_ff @(posedge CLOCK_50) begin
        if (access && !wait_done) begin
            rdata <= mem[word_idx];
        end
        if (access && wait_done && bus.pwrite) begin
            mem[word_idx] <= bus.pwdata;
        end
    end

    assign bus.pready  = wait_done;
    assign bus.prdata  = rdata;
    // Every word in range is valid
    assign bus.pslverr = 1'b0;

endmodule

`default_nettype wire

/* include/soc_params.svh */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// APB bus widths
`define SOC_ADDR_W 32
`define SOC_DATA_W 32

// Word RAM, 4 KB at the bottom of the map
`define RAM_BASE 32'h0000_0000
`define RAM_WORDS 1024

// Keyboard register block
`define KEY_BASE 32'h0000_2000
`define KEY_WORDS 3

// Register offsets inside the key block
`define KEY_DATA_OFS 4'h0
`define KEY_STATUS_OFS 4'h4
`define KEY_CTRL_OFS 4'h8

// System cycles without a PS/2 clock fall before a partial frame is dropped
`define PS2_IDLE_LIMIT 2000

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log

verilator --binary --timing --assert -Wno-fatal -f verilog.f \
    --top-module board_top_tb -o board_top_tb_sim > build.log 2>&1 \
    && ./obj_dir/board_top_tb_sim > sim.log 2>&1 \
    || echo "Something failed" >> sim.log

cat sim.log
grep -q "Something failed" sim.log \
    && { echo "Simulation FAILED (see sim.log and build.log)"; exit 1; } \
    || echo "Simulation PASSED"

/* test/board_top_sva.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module board_top_sva (
    input logic                   CLOCK_50,
    input logic                   KEY0,
    input logic                   psel,
    input logic                   penable,
    input logic [`SOC_ADDR_W-1:0] paddr,
    input logic [`SOC_DATA_W-1:0] pwdata,
    input logic                   pready,
    input logic                   pslverr,
    input logic                   irq
);

    // Setup phase always moves on to an access phase
    setup_then_access: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        psel && !penable |=> psel && penable
    ) else $error("APB setup cycle not followed by an access cycle");

    error_needs_ready: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        pslverr |-> pready
    ) else $error("pslverr high without pready");

    // Master holds the request during wait states
    stable_while_waiting: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0)
        psel && penable && !pready |=> $stable(paddr) && $stable(pwdata)
    ) else $error("paddr or pwdata changed while waiting for pready");

    irq_low_in_reset: assert property (
        @(posedge CLOCK_50) !KEY0 |-> !irq
    ) else $error("irq high during reset");

endmodule

bind board_top board_top_sva board_top_sva_inst (
    .CLOCK_50 (CLOCK_50),
    .KEY0     (KEY0),
    .psel     (psel),
    .penable  (penable),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .pready   (pready),
    .pslverr  (pslverr),
    .irq      (irq)
);

`default_nettype wire

/* test/board_top_tb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "soc_params.svh"

module board_top_tb;

    localparam logic [1:0] op_write = 2'd0;
    localparam logic [1:0] op_read  = 2'd1;
    localparam logic [1:0] op_ps2   = 2'd2;
    localparam logic [1:0] op_irq   = 2'd3;

    localparam logic [31:0] key_data   = `KEY_BASE + 32'h0;
    localparam logic [31:0] key_status = `KEY_BASE + 32'h4;
    localparam logic [31:0] key_ctrl   = `KEY_BASE + 32'h8;
    localparam logic [31:0] unmapped   = 32'h0000_3000;

    localparam int sample_ofs = 10;
    localparam int ps2_half   = 8;

    // addr holds the wait limit for irq entries
    // data holds the PS/2 byte or the irq level, err the bad parity flag
    typedef struct packed {
        logic [1:0]  kind;
        logic [31:0] addr;
        logic [31:0] data;
        logic        err;
    } entry_t;

    logic clk;
    logic rst_n;
    logic ps2_clk;
    logic ps2_dat;
    logic psel;
    logic penable;
    logic pwrite;
    logic [`SOC_ADDR_W-1:0] paddr;
    logic [`SOC_DATA_W-1:0] pwdata;
    logic [`SOC_DATA_W-1:0] prdata;
    logic pready;
    logic pslverr;
    logic irq;

    entry_t                 stim_q[$];
    entry_t                 cur;
    logic [`SOC_DATA_W-1:0] rdata;
    logic                   rerr;
    int                     n;
    int unsigned            cycle_count = 0;
    int unsigned            cycle_limit;

    tb_clock clock_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    board_top board_top_inst (
        .CLOCK_50 (clk),
        .KEY0     (rst_n),
        .PS2_CLK  (ps2_clk),
        .PS2_DAT  (ps2_dat),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .irq      (irq)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_failure(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic add_entry(input logic [1:0] kind, input logic [31:0] addr,
                             input logic [31:0] data, input logic err);
        stim_q.push_back('{kind, addr, data, err});
    endtask

    task automatic build_table();
        logic [31:0] seed;
        logic [31:0] word;
        logic [31:0] addr;
        logic [31:0] value;
        logic [31:0] word0_value;
        int i;
        seed        = 32'd39;
        addr        = '0;
        value       = '0;
        word0_value = '0;
        // First word, last word, then three random words
        for (i = 0; i < 5; i++) begin
            seed = lcg_next(seed);
            if (i == 0)
                word = 32'd0;
            else if (i == 1)
                word = 32'(`RAM_WORDS - 1);
            else
                word = {22'd0, seed[25:16]};
            seed  = lcg_next(seed);
            value = seed;
            if (word == 32'd0)
                word0_value = value;
            addr  = `RAM_BASE + (word << 2);
            add_entry(op_write, addr, value, 1'b0);
            add_entry(op_read, addr, value, 1'b0);
        end
        // Unmapped accesses, then word 0 whose index the unmapped address shares
        add_entry(op_read, unmapped, 32'h0, 1'b1);
        add_entry(op_write, unmapped, 32'hDEAD_BEEF, 1'b1);
        add_entry(op_read, `RAM_BASE, word0_value, 1'b0);
        // Make code with interrupt enabled
        add_entry(op_write, key_ctrl, 32'h1, 1'b0);
        add_entry(op_ps2, 32'h0, 32'h1C, 1'b0);
        add_entry(op_irq, 32'd20, 32'h1, 1'b0);
        add_entry(op_read, key_status, 32'h1, 1'b0);
        add_entry(op_read, key_data, 32'h01C, 1'b0);
        add_entry(op_irq, 32'd4, 32'h0, 1'b0);
        add_entry(op_read, key_status, 32'h0, 1'b0);
        // Break prefix alone, then break code
        add_entry(op_ps2, 32'h0, 32'hF0, 1'b0);
        add_entry(op_read, key_status, 32'h0, 1'b0);
        add_entry(op_ps2, 32'h0, 32'h1C, 1'b0);
        add_entry(op_irq, 32'd20, 32'h1, 1'b0);
        add_entry(op_read, key_status, 32'h1, 1'b0);
        add_entry(op_read, key_data, 32'h11C, 1'b0);
        add_entry(op_irq, 32'd4, 32'h0, 1'b0);
        add_entry(op_read, key_status, 32'h0, 1'b0);
        // Bad parity
        add_entry(op_ps2, 32'h0, 32'h1C, 1'b1);
        add_entry(op_read, key_status, 32'h4, 1'b0);
        add_entry(op_write, key_status, 32'h4, 1'b0);
        add_entry(op_read, key_status, 32'h0, 1'b0);
        // Overrun with interrupt disabled
        add_entry(op_write, key_ctrl, 32'h0, 1'b0);
        add_entry(op_ps2, 32'h0, 32'h15, 1'b0);
        add_entry(op_ps2, 32'h0, 32'h2B, 1'b0);
        add_entry(op_irq, 32'd2, 32'h0, 1'b0);
        add_entry(op_read, key_status, 32'h3, 1'b0);
        add_entry(op_write, key_status, 32'h2, 1'b0);
        add_entry(op_read, key_status, 32'h1, 1'b0);
        add_entry(op_write, key_ctrl, 32'h1, 1'b0);
        add_entry(op_irq, 32'd4, 32'h1, 1'b0);
        add_entry(op_read, key_data, 32'h02B, 1'b0);
        add_entry(op_irq, 32'd4, 32'h0, 1'b0);
        add_entry(op_read, key_status, 32'h0, 1'b0);
    endtask

    task automatic apb_transfer(input logic wr, input logic [31:0] addr,
                                input logic [31:0] wdata,
                                output logic [31:0] data_out, output logic err_out);
        int waits;
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        waits   = 0;
        // Look at the response mid low phase, ahead of the completing edge
        #(sample_ofs);
        while (pready !== 1'b1 && waits < 8) begin
            @(negedge clk);
            #(sample_ofs);
            waits++;
        end
        assert (pready === 1'b1) else
            report_failure($sformatf("APB transfer to %h never got pready", addr));
        data_out = prdata;
        err_out  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // Start, 8 data bits LSB first, odd parity, stop
    task automatic ps2_send_byte(input logic [7:0] code, input logic bad_parity);
        logic [10:0] frame;
        int b;
        frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
        for (b = 0; b < 11; b++) begin
            ps2_dat = frame[b];
            repeat (ps2_half) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (ps2_half) @(negedge clk);
            ps2_clk = 1'b1;
        end
        ps2_dat = 1'b1;
        repeat (4) @(negedge clk);
    endtask

    task automatic wait_irq(input logic level, input int limit);
        int waited;
        waited = 0;
        while (irq !== level && waited < limit) begin
            @(negedge clk);
            waited++;
        end
        assert (irq === level) else
            report_failure($sformatf("Mismatch at %0t: irq = %b, expected %b within %0d cycles",
                                     $time, irq, level, limit));
    endtask

    always @(posedge clk) begin
        if (rst_n) begin
            cycle_count <= cycle_count + 1;
            if (cycle_count > cycle_limit) begin
                $display("Timeout: no progress after %0d cycles", cycle_count);
                $display("Something failed");
                $fatal(1, "Timeout");
            end
        end
    end

    initial begin
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        build_table();
        cycle_limit = 0;
        for (n = 0; n < stim_q.size(); n++) begin
            case (stim_q[n].kind)
                op_ps2:  cycle_limit += 180;
                op_irq:  cycle_limit += stim_q[n].addr;
                default: cycle_limit += 3;
            endcase
        end
        cycle_limit = cycle_limit * 2;
        @(posedge rst_n);
        @(negedge clk);
        for (n = 0; n < stim_q.size(); n++) begin
            cur = stim_q[n];
            case (cur.kind)
                op_ps2: ps2_send_byte(cur.data[7:0], cur.err);
                op_irq: wait_irq(cur.data[0], int'(cur.addr));
                default: begin
                    apb_transfer(cur.kind == op_write, cur.addr, cur.data, rdata, rerr);
                    assert (rerr === cur.err) else
                        report_failure($sformatf(
                            "Mismatch at %0t: pslverr = %b, expected %b (%h)",
                            $time, rerr, cur.err, cur.addr));
                    if (cur.kind == op_read) begin
                        assert (rdata === cur.data) else
                            report_failure($sformatf(
                                "Mismatch at %0t: prdata = %h, expected %h (%h)",
                                $time, rdata, cur.data, cur.addr));
                    end
                end
            endcase
        end
        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* test/tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clk,
    output logic rst_n
);

    localparam int half_period  = 20;
    localparam int reset_cycles = 8;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    // Release on a falling edge, away from the DUT's active edge
    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
hdl/soc_pkg.sv
hdl/apb_if.sv
hdl/apb_decoder.sv
hdl/word_ram.sv
hdl/ps2_receiver.sv
hdl/key_regs.sv
hdl/board_top.sv
test/tb_clock.sv
test/board_top_sva.sv
test/board_top_tb.sv
